//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_branch_predictor
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
hw/bp_pkg.sv
hw/bp_if.sv
hw/bht.sv
hw/btb.sv
hw/branch_resolve.sv
hw/branch_predictor.sv
verification/bp_asserts.sv
verification/tb_branch_predictor.sv

//--- hw/bht.sv
//////////////////////////////////////////////////
// 2-bit saturating counters indexed by pc[IDX+1:2]
// BHT_ENTRIES must be a power of two
// a write is seen by lookup from the next cycle
//////////////////////////////////////////////////
`timescale 1ns/100ps

module bht
    import bp_pkg::*;
#(
    parameter int unsigned BHT_ENTRIES = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    bp_lookup_if.bht lk,
    bp_update_if.bht upd
);

    localparam int unsigned IDX_W = $clog2(BHT_ENTRIES);

    ctr_e                   ctr_q   [BHT_ENTRIES];
    logic [BHT_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    ctr_e             rd_ctr;
    ctr_e             wr_ctr;
    ctr_e             wr_next;

    assign rd_idx = IDX_W'(pc_index(lk.pc, IDX_W));
    assign wr_idx = IDX_W'(pc_index(upd.pc, IDX_W));

    assign rd_ctr  = ctr_q[rd_idx];
    assign wr_ctr  = ctr_q[wr_idx];
    assign wr_next = ctr_next(wr_ctr, upd.ctr_dir);   // saturates at both ends

    // never-trained entries predict not taken
    assign lk.ctr_taken = valid_q[rd_idx] & ctr_is_taken(rd_ctr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                ctr_q[i] <= STRONG_NT;
            end
            valid_q <= '0;
        end else if (upd.valid) begin
            ctr_q[wr_idx]   <= wr_next;
            valid_q[wr_idx] <= 1'b1;     // any resolve marks the entry trained
        end
    end

endmodule

//--- hw/bp_if.sv
//////////////////////////////////////////////////
// lookup bundle is purely combinational
// update bundle is a one-cycle strobe
// with no handshake and no back-pressure
//////////////////////////////////////////////////
`timescale 1ns/100ps

// fetch-side lookup into both tables
interface bp_lookup_if
    import bp_pkg::*;
();
    pc_t  pc;           // fetch pc
    logic ctr_taken;    // taken counter on a valid entry
    logic btb_hit;      // tag match on a valid entry
    pc_t  btb_target;   // stored target

    modport bht (
        input  pc,
        output ctr_taken
    );

    modport btb (
        input  pc,
        output btb_hit,
        output btb_target
    );
endinterface

// resolve-side write into both tables
interface bp_update_if
    import bp_pkg::*;
();
    logic valid;        // one update per high cycle
    pc_t  pc;           // branch pc
    logic taken;        // actual direction
    pc_t  target;       // actual target
    logic ctr_dir;      // 1 steps the counter up

    modport resolve (output valid, pc, taken, target, ctr_dir);

    modport bht (input valid, pc, ctr_dir);

    modport btb (input valid, pc, taken, target);
endinterface

//--- hw/bp_pkg.sv
//////////////////////////////////////////////////
// shared types and helpers for the branch predictor
// instructions are 32-bit words on word boundaries
// table sizes are powers of two
//////////////////////////////////////////////////
package bp_pkg;

    typedef logic [31:0] pc_t;

    // upper bit set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    localparam logic [31:0] INSTR_BYTES = 32'd4;
    localparam int unsigned PC_LSB      = 2;   // word offset bits below the index

    // one saturating step toward the resolved direction
    function automatic ctr_e ctr_next(ctr_e cur, logic up);
        case (cur)
            STRONG_NT: return up ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   return up ? WEAK_T   : STRONG_NT;
            WEAK_T:    return up ? STRONG_T : WEAK_NT;
            default:   return up ? STRONG_T : WEAK_T;
        endcase
    endfunction

    function automatic logic ctr_is_taken(ctr_e cur);
        return cur[1];
    endfunction

    // table index from the pc bits just above the word offset
    function automatic pc_t pc_index(pc_t pc, int unsigned idx_bits);
        return (pc >> PC_LSB) & ((pc_t'(1) << idx_bits) - pc_t'(1));
    endfunction

    // remaining upper pc bits
    function automatic pc_t pc_tag(pc_t pc, int unsigned idx_bits);
        return pc >> (idx_bits + PC_LSB);
    endfunction

endpackage

//--- hw/branch_predictor.sv
//////////////////////////////////////////////////
// branch prediction unit top
// fetch lookup is combinational with no stall input
// one resolve per cycle from the memory stage
//////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_predictor
    import bp_pkg::*;
#(
    parameter int unsigned BHT_ENTRIES = 256,
    parameter int unsigned BTB_ENTRIES = 64
) (
    input  logic clk,
    input  logic rst_n,

    // fetch stage
    input  pc_t  fetch_pc,
    output logic pred_taken,
    output pc_t  pred_target,
    output logic pred_hit,

    // memory stage
    input  logic resolve_valid,
    input  pc_t  resolve_pc,
    input  logic resolve_taken,
    input  pc_t  resolve_target,
    input  logic resolve_pred_taken,
    input  pc_t  resolve_pred_target,
    output logic mispredict,
    output pc_t  redirect_pc
);

    bp_lookup_if lk_if ();
    bp_update_if upd_if ();

    assign lk_if.pc = fetch_pc;

    // taken needs both a taken counter and a known target
    assign pred_taken  = lk_if.ctr_taken & lk_if.btb_hit;
    assign pred_target = lk_if.btb_target;
    assign pred_hit    = lk_if.btb_hit;

    bht #(
        .BHT_ENTRIES (BHT_ENTRIES)
    ) u_bht (
        .clk   (clk),
        .rst_n (rst_n),
        .lk    (lk_if),
        .upd   (upd_if)
    );

    btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk   (clk),
        .rst_n (rst_n),
        .lk    (lk_if),
        .upd   (upd_if)
    );

    branch_resolve u_resolve (
        .clk                 (clk),
        .rst_n               (rst_n),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .upd                 (upd_if),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

endmodule

//--- hw/branch_resolve.sv
//////////////////////////////////////////////////
// memory-stage check of a branch against its prediction
// table update goes out in the resolve cycle
// mispredict and redirect come one cycle later
//////////////////////////////////////////////////
`timescale 1ns/100ps

module branch_resolve
    import bp_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic resolve_valid,
    input  pc_t  resolve_pc,
    input  logic resolve_taken,
    input  pc_t  resolve_target,
    input  logic resolve_pred_taken,
    input  pc_t  resolve_pred_target,
    bp_update_if.resolve upd,
    output logic mispredict,
    output pc_t  redirect_pc
);

    logic dir_wrong;
    logic tgt_wrong;
    logic wrong;
    pc_t  fix_pc;

    assign dir_wrong = resolve_taken != resolve_pred_taken;
    assign tgt_wrong = resolve_taken && resolve_pred_taken
                       && (resolve_target != resolve_pred_target);
    assign wrong     = dir_wrong | tgt_wrong;

    // where fetch must restart
    assign fix_pc = resolve_taken ? resolve_target : resolve_pc + INSTR_BYTES;

    // every resolve trains the tables
    assign upd.valid   = resolve_valid;
    assign upd.pc      = resolve_pc;
    assign upd.taken   = resolve_taken;
    assign upd.target  = resolve_target;
    assign upd.ctr_dir = resolve_taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mispredict <= 1'b0;
        end else begin
            mispredict <= resolve_valid & wrong;   // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            redirect_pc <= fix_pc;   // only meaningful with mispredict
        end
    end

endmodule

//--- hw/btb.sv
//////////////////////////////////////////////////
// direct-mapped target buffer with full upper-pc tag
// BTB_ENTRIES must be a power of two
// only taken resolves allocate and the newest one wins
//////////////////////////////////////////////////
`timescale 1ns/100ps

module btb
    import bp_pkg::*;
#(
    parameter int unsigned BTB_ENTRIES = 64
) (
    input  logic    clk,
    input  logic    rst_n,
    bp_lookup_if.btb lk,
    bp_update_if.btb upd
);

    localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
    localparam int unsigned TAG_W = 32 - IDX_W - PC_LSB;

    logic [TAG_W-1:0]       tag_q    [BTB_ENTRIES];
    pc_t                    target_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    assign rd_idx = IDX_W'(pc_index(lk.pc, IDX_W));
    assign rd_tag = TAG_W'(pc_tag(lk.pc, IDX_W));
    assign wr_idx = IDX_W'(pc_index(upd.pc, IDX_W));
    assign wr_tag = TAG_W'(pc_tag(upd.pc, IDX_W));

    assign wr_en = upd.valid & upd.taken;   // not-taken leaves the entry alone

    assign lk.btb_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign lk.btb_target = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload from taken resolves
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;     // replaces any aliasing branch
            target_q[wr_idx] <= upd.target;
        end
    end

endmodule

//--- verification/bp_asserts.sv
//////////////////////////////////////////////////
// concurrent checks bound into branch_predictor
// sampled on the rising clock edge
//////////////////////////////////////////////////
`timescale 1ns/100ps

module bp_asserts (
    input logic clk,
    input logic rst_n,
    input logic resolve_valid,
    input logic mispredict,
    input logic pred_taken,
    input logic pred_hit
);

    // back-to-back pulses need back-to-back resolves
    property mispredict_needs_resolves;
        @(posedge clk) disable iff (!rst_n)
            (mispredict && $past(mispredict))
                |-> ($past(resolve_valid) && $past(resolve_valid, 2));
    endproperty

    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !mispredict;
    endproperty

    property taken_needs_hit;
        @(posedge clk) disable iff (!rst_n) pred_taken |-> pred_hit;
    endproperty

    assert property (mispredict_needs_resolves)
        else $error("mispredict held high without a resolve in each cycle");
    assert property (quiet_after_reset)
        else $error("mispredict high in the first cycle after reset");
    assert property (taken_needs_hit)
        else $error("taken prediction without a btb hit");

endmodule

bind branch_predictor bp_asserts u_bp_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .resolve_valid (resolve_valid),
    .mispredict    (mispredict),
    .pred_taken    (pred_taken),
    .pred_hit      (pred_hit)
);

//--- verification/tb_branch_predictor.sv
//////////////////////////////////////////////////
// testbench for branch_predictor with default table sizes
// inputs change on the falling edge, outputs are checked there
//////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int unsigned BHT_ENTRIES = 256;
    localparam int unsigned BTB_ENTRIES = 64;
    localparam int unsigned SEED        = 95123;
    localparam int unsigned RAND_COUNT  = 1000;
    localparam int unsigned MAX_CYCLES  = 2000;   // reset, directed tests and random stream

    localparam logic [31:0] PC_A  = 32'h0000_1040;
    localparam logic [31:0] PC_B  = 32'h0000_1080;
    localparam logic [31:0] TGT_A = 32'h0000_2000;
    localparam logic [31:0] TGT_B = 32'h0000_3000;

    logic        clk;
    logic        rst_n;
    logic [31:0] fetch_pc;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        pred_hit;
    logic        resolve_valid;
    logic [31:0] resolve_pc;
    logic        resolve_taken;
    logic [31:0] resolve_target;
    logic        resolve_pred_taken;
    logic [31:0] resolve_pred_target;
    logic        mispredict;
    logic [31:0] redirect_pc;

    string       test_name;
    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;

    // mirror of both tables
    int unsigned ctr_model  [BHT_ENTRIES];   // 0 strong not taken .. 3 strong taken
    bit          ctr_seen   [BHT_ENTRIES];
    bit          btb_valid  [BTB_ENTRIES];
    logic [31:0] btb_tag    [BTB_ENTRIES];
    logic [31:0] btb_target [BTB_ENTRIES];

    branch_predictor #(
        .BHT_ENTRIES (BHT_ENTRIES),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) DUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .fetch_pc            (fetch_pc),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .pred_hit            (pred_hit),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    function automatic int unsigned bht_slot(input logic [31:0] pc);
        return (pc >> 2) % BHT_ENTRIES;
    endfunction

    function automatic int unsigned btb_slot(input logic [31:0] pc);
        return (pc >> 2) % BTB_ENTRIES;
    endfunction

    function automatic logic [31:0] btb_tag_of(input logic [31:0] pc);
        return pc / (BTB_ENTRIES * 4);   // pc bits above the btb index
    endfunction

    // {pred_taken, pred_hit, pred_target} for a fetch pc
    function automatic logic [33:0] expected_prediction(input logic [31:0] pc);
        int unsigned bi;
        int unsigned ti;
        logic        ctr_t;
        logic        hit;
        bi    = bht_slot(pc);
        ti    = btb_slot(pc);
        ctr_t = ctr_seen[bi] && (ctr_model[bi] >= 2);
        hit   = btb_valid[ti] && (btb_tag[ti] == btb_tag_of(pc));
        return {ctr_t & hit, hit, btb_target[ti]};
    endfunction

    // {mispredict, redirect_pc} for one resolve
    function automatic logic [32:0] expected_resolve(input logic valid, input logic [31:0] pc,
                                                     input logic taken, input logic [31:0] target,
                                                     input logic p_taken,
                                                     input logic [31:0] p_target);
        logic        mis;
        logic [31:0] redirect;
        mis      = valid && ((taken != p_taken) || (taken && p_taken && target != p_target));
        redirect = taken ? target : pc + 32'd4;
        return {mis, redirect};
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            ctr_model[i] = 0;
            ctr_seen[i]  = 1'b0;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            btb_valid[i] = 1'b0;
        end
    endfunction

    function automatic void train_model(input logic [31:0] pc, input logic taken,
                                        input logic [31:0] target);
        int unsigned bi;
        int unsigned ti;
        bi = bht_slot(pc);
        ti = btb_slot(pc);
        if (taken && ctr_model[bi] < 3) begin
            ctr_model[bi] = ctr_model[bi] + 1;
        end else if (!taken && ctr_model[bi] > 0) begin
            ctr_model[bi] = ctr_model[bi] - 1;
        end
        ctr_seen[bi] = 1'b1;
        if (taken) begin
            btb_valid[ti]  = 1'b1;
            btb_tag[ti]    = btb_tag_of(pc);
            btb_target[ti] = target;
        end
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %s %s: expected %h, got %h", test_name, what, exp, act);
        end
    endtask

    // outputs seen here come from the inputs of the previous falling edge
    always @(negedge clk) begin : compare_outputs
        logic [33:0] exp_pred;
        logic [32:0] exp_res;
        if (!rst_n) begin
            clear_model();
            check("mispredict in reset", 32'h0, 32'(mispredict));
        end else begin
            exp_res = expected_resolve(resolve_valid, resolve_pc, resolve_taken,
                                       resolve_target, resolve_pred_taken, resolve_pred_target);
            check("mispredict", 32'(exp_res[32]), 32'(mispredict));
            if (resolve_valid) begin
                check("redirect_pc", exp_res[31:0], redirect_pc);
                train_model(resolve_pc, resolve_taken, resolve_target);   // written at the edge
            end
            exp_pred = expected_prediction(fetch_pc);
            check("pred_taken", 32'(exp_pred[33]), 32'(pred_taken));
            check("pred_hit", 32'(exp_pred[32]), 32'(pred_hit));
            if (exp_pred[32]) begin
                check("pred_target", exp_pred[31:0], pred_target);
            end
        end
    end

    task automatic drive_idle(input logic [31:0] pc);
        @(negedge clk);
        resolve_valid <= 1'b0;
        fetch_pc      <= pc;
    endtask

    task automatic drive_resolve(input logic [31:0] pc, input logic taken,
                                 input logic [31:0] target, input logic p_taken,
                                 input logic [31:0] p_target);
        @(negedge clk);
        resolve_valid       <= 1'b1;
        resolve_pc          <= pc;
        resolve_taken       <= taken;
        resolve_target      <= target;
        resolve_pred_taken  <= p_taken;
        resolve_pred_target <= p_target;
        fetch_pc            <= pc;
    endtask

    task automatic expect_lookup(input logic [31:0] pc, input logic exp_taken);
        drive_idle(pc);
        @(negedge clk);
        check("lookup taken", 32'(exp_taken), 32'(pred_taken));
    endtask

    task automatic resolve_checked(input logic [31:0] pc, input logic taken,
                                   input logic [31:0] target, input logic p_taken,
                                   input logic [31:0] p_target, input logic exp_mis,
                                   input logic [31:0] exp_redirect);
        drive_resolve(pc, taken, target, p_taken, p_target);
        drive_idle(pc);   // pulse from the resolve is visible now
        check("mispredict pulse", 32'(exp_mis), 32'(mispredict));
        if (exp_mis) begin
            check("redirect target", exp_redirect, redirect_pc);
        end
    endtask

    function automatic logic [31:0] random_pc();
        // four tags over eight shared indexes
        return 32'h0000_4000 | (($urandom % 4) << 10) | (($urandom % 8) << 2);
    endfunction

    function automatic logic [31:0] random_target();
        return 32'h0000_8000 + (($urandom % 4) << 4);
    endfunction

    task automatic random_cycle();
        @(negedge clk);
        resolve_valid       <= ($urandom % 4) != 0;
        resolve_pc          <= random_pc();
        resolve_taken       <= 1'($urandom);
        resolve_target      <= random_target();
        resolve_pred_taken  <= 1'($urandom);
        resolve_pred_target <= random_target();
        fetch_pc            <= random_pc();
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n               = 1'b0;
        fetch_pc            = 32'h0;
        resolve_valid       = 1'b0;
        resolve_pc          = 32'h0;
        resolve_taken       = 1'b0;
        resolve_target      = 32'h0;
        resolve_pred_taken  = 1'b0;
        resolve_pred_target = 32'h0;
        test_name           = "reset";
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;

        expect_lookup(32'h0000_1000, 1'b0);
        expect_lookup(32'h0000_2468, 1'b0);

        test_name <= "train";
        drive_resolve(PC_A, 1'b1, TGT_A, 1'b0, 32'h0);   // to WEAK_NT
        drive_resolve(PC_A, 1'b1, TGT_A, 1'b0, 32'h0);   // to WEAK_T
        expect_lookup(PC_A, 1'b1);

        test_name <= "hysteresis";
        resolve_checked(PC_A, 1'b1, TGT_A, 1'b1, TGT_A, 1'b0, 32'h0);   // STRONG_T
        resolve_checked(PC_A, 1'b0, TGT_A, 1'b1, TGT_A, 1'b1, PC_A + 32'd4);
        expect_lookup(PC_A, 1'b1);
        drive_resolve(PC_A, 1'b0, TGT_A, 1'b1, TGT_A);
        expect_lookup(PC_A, 1'b0);

        test_name <= "mispredict";
        resolve_checked(PC_A, 1'b1, TGT_A, 1'b0, 32'h0, 1'b1, TGT_A);
        resolve_checked(PC_A, 1'b1, TGT_B, 1'b1, TGT_A, 1'b1, TGT_B);   // target moved
        resolve_checked(PC_A, 1'b1, TGT_B, 1'b1, TGT_B, 1'b0, 32'h0);
        resolve_checked(PC_B, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        expect_lookup(PC_A, 1'b1);

        test_name <= "alias";
        expect_lookup(PC_A + 32'h0001_0000, 1'b0);   // same index, other tag

        test_name <= "random";
        for (int i = 0; i < RAND_COUNT; i++) begin
            random_cycle();
        end
        drive_idle(32'h0);
        drive_idle(32'h0);
        @(posedge clk);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
